// File: verilog/timing_macros.svh
`ifndef TIMING_MACROS_SVH
`define TIMING_MACROS_SVH

// bus widths
`define ADDR_WIDTH 16
`define DATA_WIDTH 8

// low byte of each vector, high byte is the next address
`define RESET_VECTOR 16'hFFFC
`define IRQ_VECTOR   16'hFFFE

`endif

// File: verilog/timingPkg.sv
`include "timing_macros.svh"

package timingPkg;

    typedef enum logic [1:0] {
        fsmInit     = 2'd0,  // reset setup
        fsmFetch    = 2'd1,
        fsmExecNorm = 2'd2,
        fsmExecBrk  = 2'd3
    } fsmState_t;

    // tZero..tSix one-hot; the three branch T1 codes sit between them
    typedef enum logic [6:0] {
        emptyT          = 7'h00,
        tZero           = 7'h01,
        tOne            = 7'h02,
        tTwo            = 7'h04,
        tThree          = 7'h08,
        tFour           = 7'h10,
        tFive           = 7'h20,
        tSix            = 7'h40,
        t1NoBranch      = 7'h03,
        t1BranchNoCross = 7'h05,
        t1BranchCross   = 7'h06
    } tState_t;

    typedef enum logic [2:0] {
        opImplied   = 3'd0,
        opImmediate = 3'd1,
        opZeroPage  = 3'd2,
        opAbsolute  = 3'd3,
        opBranch    = 3'd4,
        opBrk       = 3'd5
    } opClass_t;

    typedef struct packed {
        opClass_t   opClass;
        logic [2:0] lastT;    // index of the final T before wrapping to T0
        logic [1:0] condSel;  // branch flag select
        logic       condVal;
        logic       isBrk;
    } opInfo_t;

    typedef struct packed {
        logic                   rdy;
        logic [`DATA_WIDTH-1:0] opcode;
        logic [`DATA_WIDTH-1:0] operand;
        logic                   pageCross;
    } fetchStat_t;

endpackage

// File: verilog/opcodeDecode.sv
`include "timing_macros.svh"

module opcodeDecode import timingPkg::*; (
    input  logic       phi1,
    input  logic       rst,
    input  fetchStat_t fetch,
    output opInfo_t    info
);

    logic [`DATA_WIDTH-1:0] heldOp;
    opInfo_t                held;
    opInfo_t                decoded;
    logic [2:0]             aaa;
    logic [2:0]             bbb;
    logic [1:0]             cc;

    assign aaa = fetch.opcode[7:5];
    assign bbb = fetch.opcode[4:2];
    assign cc  = fetch.opcode[1:0];

    always_comb begin
        decoded.condSel = fetch.opcode[7:6];
        decoded.condVal = fetch.opcode[5];
        decoded.isBrk   = 1'b0;
        decoded.opClass = opImplied;
        if (fetch.opcode == 8'h00) begin
            decoded.opClass = opBrk;
            decoded.isBrk   = 1'b1;
        end else if (fetch.opcode[4:0] == 5'b10000) begin
            decoded.opClass = opBranch;
        end else if (cc != 2'b11) begin  // cc=11 is unused, left as implied
            case (bbb)
                3'b000: begin
                    if (cc == 2'b01)
                        decoded.opClass = opAbsolute;  // (zp,x) approximated
                    else if (cc == 2'b10 || aaa[2])
                        decoded.opClass = opImmediate;  // LDX/LDY/CPY/CPX #
                end
                3'b001, 3'b101: decoded.opClass = opZeroPage;
                3'b010: begin
                    if (cc == 2'b01)
                        decoded.opClass = opImmediate;
                end
                3'b011, 3'b111: decoded.opClass = opAbsolute;
                default: begin  // 100 and 110
                    if (cc == 2'b01)
                        decoded.opClass = opAbsolute;  // indexed forms
                end
            endcase
        end

        case (decoded.opClass)
            opZeroPage: decoded.lastT = 3'd2;
            opAbsolute: decoded.lastT = 3'd3;
            opBrk:      decoded.lastT = 3'd6;
            default:    decoded.lastT = 3'd1;  // implied, immediate, untaken branch
        endcase
    end

    // keep the decode of the running opcode, refresh when the latch moves
    always_ff @(posedge phi1) begin
        if (rst) begin
            heldOp       <= 8'hEA;  // NOP
            held.opClass <= opImplied;
            held.lastT   <= 3'd1;
            held.condSel <= 2'b11;
            held.condVal <= 1'b1;
            held.isBrk   <= 1'b0;
        end else if (fetch.opcode != heldOp) begin
            heldOp <= fetch.opcode;
            held   <= decoded;
        end
    end

    // new byte on the bus during T1 is decoded straight through
    assign info = (fetch.opcode == heldOp) ? held : decoded;

endmodule

// File: verilog/tStateSequencer.sv
`include "timing_macros.svh"

module tStateSequencer import timingPkg::*; (
    input  logic                   phi1,
    input  logic                   rst,
    input  opInfo_t                info,
    input  fetchStat_t             fetch,
    input  logic [`DATA_WIDTH-1:0] flags,
    input  logic                   irq,
    input  tState_t                currT,
    input  fsmState_t              currState,
    input  logic                   intHandled,
    output tState_t                nextT,
    output logic                   brkNow
);

    logic    irqPrev;
    logic    irqPending;
    logic    flagBit;
    logic    takenNow;
    logic    takenReg;  // branch outcome, held until T0
    tState_t stepT;
    tState_t lastCode;

    // N V C Z, in 6502 branch opcode order
    always_comb begin
        case (info.condSel)
            2'd0:    flagBit = flags[7];
            2'd1:    flagBit = flags[6];
            2'd2:    flagBit = flags[0];
            default: flagBit = flags[1];
        endcase
    end

    assign takenNow = (flagBit == info.condVal);
    assign stepT    = tState_t'(currT << 1);
    assign lastCode = tState_t'(7'd1 << info.lastT);
    assign brkNow   = info.isBrk | irqPending;

    always_comb begin
        nextT = tOne;
        case (currState)
            fsmInit: begin
                nextT = (currT == tSix) ? tOne : stepT;
            end
            fsmFetch: begin
                if (brkNow)
                    nextT = tTwo;
                else if (info.opClass == opBranch)
                    nextT = takenNow ? tTwo : tZero;
                else
                    nextT = (info.lastT == 3'd1) ? tZero : tTwo;
            end
            fsmExecNorm: begin
                if (currT == tZero) begin
                    if (info.opClass != opBranch)
                        nextT = tOne;
                    else if (!takenReg)
                        nextT = t1NoBranch;
                    else
                        nextT = fetch.pageCross ? t1BranchCross : t1BranchNoCross;
                end else if (info.opClass == opBranch) begin
                    // extra T3 only on a page cross
                    nextT = (currT == tTwo && fetch.pageCross) ? tThree : tZero;
                end else begin
                    nextT = (currT == lastCode) ? tZero : stepT;
                end
            end
            fsmExecBrk: begin
                if (currT == tSix)
                    nextT = tZero;
                else if (currT == tZero)
                    nextT = tOne;
                else
                    nextT = stepT;
            end
            default: nextT = tOne;
        endcase
    end

    always_ff @(posedge phi1) begin
        if (rst) begin
            irqPrev    <= 1'b0;
            irqPending <= 1'b0;
            takenReg   <= 1'b0;
        end else begin
            irqPrev    <= irq;
            irqPending <= (irqPending & ~intHandled) | (irq & ~irqPrev);
            if (fetch.rdy && currState == fsmFetch)
                takenReg <= takenNow && (info.opClass == opBranch);
        end
    end

endmodule

// File: verilog/plaFSM.sv
module plaFSM import timingPkg::*; (
    input  logic      phi1,
    input  logic      rst,
    input  logic      RDY,
    input  logic      brkNow,
    input  tState_t   nextT,
    output tState_t   currT,
    output fsmState_t currState,
    output logic      intHandled,
    output logic      rstAll
);

    fsmState_t nextState;
    logic      nextIntHandled;
    logic      nextIsT1;

    // any flavour of T1 ends the running instruction
    assign nextIsT1 = (nextT == tOne) || (nextT == t1NoBranch) ||
                      (nextT == t1BranchNoCross) || (nextT == t1BranchCross);

    always_comb begin
        nextState      = currState;
        nextIntHandled = 1'b0;
        case (currState)
            fsmInit: begin
                if (nextT == tOne)  // setup sequence done
                    nextState = fsmFetch;
            end
            fsmFetch: begin
                // opcode is still on the bus here, decode is combinational
                nextState = brkNow ? fsmExecBrk : fsmExecNorm;
            end
            fsmExecNorm: begin
                if (nextIsT1)
                    nextState = fsmFetch;
            end
            fsmExecBrk: begin
                if (nextT == tZero)
                    nextIntHandled = 1'b1;
                else if (nextT == tOne)
                    nextState = fsmFetch;
            end
            default: nextState = fsmInit;
        endcase
    end

    always_ff @(posedge phi1) begin
        if (rst) begin
            currT      <= tTwo;  // setup starts at T2 like a BRK
            currState  <= fsmInit;
            intHandled <= 1'b0;
        end else if (RDY) begin
            currT      <= nextT;
            currState  <= nextState;
            intHandled <= nextIntHandled;
        end
    end

    // one pulse per reset, independent of bus stalls
    always_ff @(posedge phi1) begin
        rstAll <= rst;
    end

endmodule

// File: verilog/busFetch.sv
`include "timing_macros.svh"

module busFetch import timingPkg::*; (
    input  logic                   phi1,
    input  logic                   rst,
    input  tState_t                currT,
    input  fsmState_t              currState,
    input  tState_t                nextT,
    input  logic [`DATA_WIDTH-1:0] wbDatI,
    input  logic                   wbAck,
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic                   wbWe,
    output logic [`ADDR_WIDTH-1:0] wbAdr,
    output logic                   sync,
    output fetchStat_t             fetch
);

    logic                   busy;  // cyc and stb together
    logic                   ackNow;
    logic [`ADDR_WIDTH-1:0] pc;
    logic [`ADDR_WIDTH-1:0] pcNext;
    logic [`ADDR_WIDTH-1:0] target;
    logic [`ADDR_WIDTH-1:0] targetReg;
    logic [`ADDR_WIDTH-1:0] vecBase;
    logic [`ADDR_WIDTH-1:0] vecPc;
    logic [`DATA_WIDTH-1:0] opcodeReg;
    logic [`DATA_WIDTH-1:0] operandReg;
    logic [`DATA_WIDTH-1:0] operandNow;
    logic [`DATA_WIDTH-1:0] vecLo;
    logic [`DATA_WIDTH-1:0] vecHi;
    logic                   crossReg;
    logic                   liveCross;
    logic                   opRead;
    logic                   vecPhase;
    logic                   vecRead;
    logic                   vecLoad;
    logic                   branchLoad;

    assign ackNow = busy & wbAck;
    assign opRead = (currState == fsmFetch);

    // reset setup and BRK both end with the vector pair
    assign vecPhase = (currState == fsmInit) || (currState == fsmExecBrk);
    assign vecRead  = vecPhase && (currT == tFive || currT == tSix);
    assign vecBase  = (currState == fsmInit) ? `RESET_VECTOR : `IRQ_VECTOR;
    assign vecPc    = {(currT == tSix) ? wbDatI : vecHi, vecLo};
    assign vecLoad  = vecPhase && (nextT == tOne);

    assign branchLoad = (nextT == t1BranchNoCross) || (nextT == t1BranchCross);

    // offset byte is live on the bus during T2
    assign operandNow = (currT == tTwo) ? wbDatI : operandReg;
    assign pcNext     = pc + 1'b1;
    assign target     = pcNext +
                        {{(`ADDR_WIDTH-`DATA_WIDTH){operandNow[`DATA_WIDTH-1]}}, operandNow};
    assign liveCross  = (target[`ADDR_WIDTH-1:8] != pcNext[`ADDR_WIDTH-1:8]);

    always_comb begin
        if (!vecRead)
            wbAdr = pc;
        else if (currT == tSix)
            wbAdr = vecBase + 1'b1;
        else
            wbAdr = vecBase;
    end

    assign wbCyc = busy;
    assign wbStb = busy;
    assign wbWe  = 1'b0;
    assign sync  = busy & opRead;

    assign fetch.rdy       = rst | ackNow;  // also high while nothing is pending
    assign fetch.opcode    = opRead ? wbDatI : opcodeReg;
    assign fetch.operand   = operandNow;
    assign fetch.pageCross = (currT == tTwo) ? liveCross : crossReg;

    always_ff @(posedge phi1) begin
        if (rst) begin
            busy <= 1'b0;
            pc   <= '0;
        end else begin
            busy <= busy ? ~wbAck : 1'b1;  // one idle cycle after each ack
            if (ackNow) begin
                if (vecLoad)
                    pc <= vecPc;
                else if (branchLoad)
                    pc <= targetReg;
                else if (!vecRead)
                    pc <= pcNext;
            end
        end
    end

    always_ff @(posedge phi1) begin
        if (ackNow) begin
            if (opRead)
                opcodeReg <= wbDatI;
            if (currT == tTwo) begin
                operandReg <= wbDatI;
                targetReg  <= target;
                crossReg   <= liveCross;
            end
            if (vecRead && currT == tFive)
                vecLo <= wbDatI;
            if (vecRead && currT == tSix)
                vecHi <= wbDatI;
        end
    end

endmodule

// File: verilog/timingCore.sv
`include "timing_macros.svh"

module timingCore import timingPkg::*; (
    input  logic                   phi1,
    input  logic                   rst,
    input  logic                   irq,
    input  logic [`DATA_WIDTH-1:0] flags,
    input  logic [`DATA_WIDTH-1:0] wbDatI,
    input  logic                   wbAck,
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic                   wbWe,
    output logic [`ADDR_WIDTH-1:0] wbAdr,
    output tState_t                currT,
    output fsmState_t              currState,
    output logic                   intHandled,
    output logic                   rstAll,
    output logic                   sync
);

    fetchStat_t fetch;
    opInfo_t    info;
    tState_t    nextT;
    logic       brkNow;

    opcodeDecode i_opcodeDecode (
        .phi1  (phi1),
        .rst   (rst),
        .fetch (fetch),
        .info  (info)
    );

    tStateSequencer i_tStateSequencer (
        .phi1       (phi1),
        .rst        (rst),
        .info       (info),
        .fetch      (fetch),
        .flags      (flags),
        .irq        (irq),
        .currT      (currT),
        .currState  (currState),
        .intHandled (intHandled),
        .nextT      (nextT),
        .brkNow     (brkNow)
    );

    // T-state only steps when the bus says so
    plaFSM i_plaFSM (
        .phi1       (phi1),
        .rst        (rst),
        .RDY        (fetch.rdy),
        .brkNow     (brkNow),
        .nextT      (nextT),
        .currT      (currT),
        .currState  (currState),
        .intHandled (intHandled),
        .rstAll     (rstAll)
    );

    busFetch i_busFetch (
        .phi1      (phi1),
        .rst       (rst),
        .currT     (currT),
        .currState (currState),
        .nextT     (nextT),
        .wbDatI    (wbDatI),
        .wbAck     (wbAck),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .sync      (sync),
        .fetch     (fetch)
    );

endmodule

// File: bench/timingCore_tb.sv
module timingCore_tb import timingPkg::*; ();
    timeunit 1ns;
    timeprecision 1ns;

    logic        phi1 = 1'b0;
    logic        rst;
    logic        irq;
    logic [7:0]  flags;
    logic [7:0]  wbDatI;
    logic        wbAck;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [15:0] wbAdr;
    logic [6:0]  currT;
    logic [1:0]  currState;
    logic        intHandled;
    logic        rstAll;
    logic        sync;

    logic [7:0]  mem [0:65535];
    logic [15:0] expAdr [$];
    logic        expSync [$];
    logic [6:0]  expT [$];
    logic [7:0]  expFlags [$];
    logic        expIrq [$];
    logic [1:0]  expState [$];

    int   readIdx = 0;
    int   waitLeft = 0;
    int   traceLen = 0;
    int   rstRises = 0;
    int   intRises = 0;
    bit   loaded = 1'b0;
    bit   traceDone = 1'b0;
    logic rstAllPrev = 1'b0;
    logic intPrev = 1'b0;

    timingCore i_timingCore (
        .phi1(phi1), .rst(rst), .irq(irq), .flags(flags),
        .wbDatI(wbDatI), .wbAck(wbAck), .wbCyc(wbCyc), .wbStb(wbStb),
        .wbWe(wbWe), .wbAdr(wbAdr), .currT(currT), .currState(currState),
        .intHandled(intHandled), .rstAll(rstAll), .sync(sync)
    );

    always #10 phi1 = ~phi1;  // 20 ns period

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic loadTestData();
        int          fd;
        int          c;
        int          n;
        int          i;
        logic [15:0] a;
        logic [7:0]  d;
        logic [7:0]  s;
        logic [7:0]  t;
        logic [7:0]  f;
        logic [7:0]  q;
        string       line;
        for (i = 0; i < 65536; i++)
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h3C;  // background fill
        fd = $fopen("bench/testdata_timing.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file bench/testdata_timing.txt");
            $display("RESULT: FAIL");
            $fatal(1, "missing test data");
        end
        while (!$feof(fd)) begin
            c = $fgetc(fd);
            if (c == "M") begin
                n = $fscanf(fd, " %h %h", a, d);
                mem[a] = d;
            end else if (c == "R") begin
                n = $fscanf(fd, " %h %h %h %h %h", a, s, t, f, q);
                expAdr.push_back(a);
                expSync.push_back(s[0]);
                expT.push_back(t[6:0]);
                expFlags.push_back(f);
                expIrq.push_back(q[0]);
            end else if (c == "#") begin
                n = $fgets(line, fd);  // rest of a comment line
            end
        end
        $fclose(fd);
        traceLen = expAdr.size();
    endtask

    // phase of each read: setup before the first sync, fetch on sync,
    // BRK execution when the instruction reads the IRQ vector
    task automatic deriveFsmStates();
        int i;
        int j;
        bit seenSync;
        bit isBrk;
        seenSync = 1'b0;
        isBrk    = 1'b0;
        for (i = 0; i < traceLen; i++) begin
            if (expSync[i]) begin
                seenSync = 1'b1;
                isBrk    = 1'b0;
                for (j = i + 1; j < traceLen && !expSync[j]; j++)
                    if (expAdr[j] == 16'hFFFE)
                        isBrk = 1'b1;
                expState.push_back(fsmFetch);
            end else if (!seenSync) begin
                expState.push_back(fsmInit);
            end else begin
                expState.push_back(isBrk ? fsmExecBrk : fsmExecNorm);
            end
        end
    endtask

    // slave memory, 0 to 3 idle cycles before each ack
    always @(posedge phi1) begin
        if (rst) begin
            wbAck <= 1'b0;
        end else if (wbAck) begin
            wbAck    <= 1'b0;
            waitLeft <= int'($urandom() & 32'h3);
        end else if (wbStb) begin
            if (waitLeft == 0) begin
                wbAck  <= 1'b1;
                wbDatI <= mem[wbAdr];
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

    // compare every acknowledged read with the trace
    always @(posedge phi1) begin
        if (!rst && !traceDone && wbStb && wbAck) begin
            checkValue("wbAdr", 32'(wbAdr), 32'(expAdr[readIdx]));
            checkValue("sync", 32'(sync), 32'(expSync[readIdx]));
            checkValue("currT", 32'(currT), 32'(expT[readIdx]));
            checkValue("currState", 32'(currState), 32'(expState[readIdx]));
            checkValue("wbWe", 32'(wbWe), 32'h0);
            if (readIdx + 1 < traceLen) begin
                flags <= expFlags[readIdx + 1];
                irq   <= expIrq[readIdx + 1];
            end else begin
                traceDone <= 1'b1;
            end
            readIdx <= readIdx + 1;
        end
    end

    always @(posedge phi1) begin
        rstAllPrev <= rstAll;
        intPrev    <= intHandled;
        if (rstAll === 1'b1 && rstAllPrev !== 1'b1)
            rstRises <= rstRises + 1;
        if (intHandled && !intPrev)
            intRises <= intRises + 1;
    end

    initial begin
        void'($urandom(32'h94d5cc3b));
        rst     = 1'b1;
        irq     = 1'b0;
        flags   = 8'h00;
        wbDatI  = 8'h00;
        wbAck   = 1'b0;
        loadTestData();
        deriveFsmStates();
        flags   = expFlags[0];
        irq     = expIrq[0];
        loaded  = 1'b1;
        repeat (16) @(posedge phi1);
        // bus and strobes quiet while in reset
        checkValue("wbCyc", 32'(wbCyc), 32'h0);
        checkValue("wbStb", 32'(wbStb), 32'h0);
        checkValue("sync", 32'(sync), 32'h0);
        checkValue("intHandled", 32'(intHandled), 32'h0);
        rst <= 1'b0;
        while (!traceDone)
            @(posedge phi1);
        checkValue("rstAll pulses", 32'(rstRises), 32'd1);
        checkValue("intHandled pulses", 32'(intRises), 32'd2);  // BRK and irq
        $display("RESULT: PASS");
        $finish;
    end

    // worst case read is six cycles
    initial begin
        wait (loaded);
        repeat (16 + traceLen * 7 + 40) @(posedge phi1);
        $display("timeout: the read trace did not complete in time");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: build.f
+incdir+verilog
verilog/timingPkg.sv
verilog/opcodeDecode.sv
verilog/tStateSequencer.sv
verilog/plaFSM.sv
verilog/busFetch.sv
verilog/timingCore.sv
bench/timingCore_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    -f build.f --top-module timingCore_tb -Mdir obj_dir || exit 1

./obj_dir/VtimingCore_tb | tee /dev/stderr | grep -qx "RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: bench/testdata_timing.txt
# M addr data              : memory image byte
# R addr sync currT flags irq : expected read, flags and irq driven during it
M FFFC 00
M FFFD 02
M FFFE 00
M FFFF 03
M 0200 EA
M 0202 A9
M 0204 A5
M 0207 AD
M 020B D0
M 020D D0
M 020E 05
M 0214 F0
M 0215 E0
M 01F6 00
M 0300 AD
M 0304 EA
R 0000 0 04 00 0
R 0001 0 08 00 0
R 0002 0 10 00 0
R FFFC 0 20 00 0
R FFFD 0 40 00 0
R 0200 1 02 00 0
R 0201 0 01 00 0
R 0202 1 02 00 0
R 0203 0 01 00 0
R 0204 1 02 00 0
R 0205 0 04 00 0
R 0206 0 01 00 0
R 0207 1 02 00 0
R 0208 0 04 00 0
R 0209 0 08 00 0
R 020A 0 01 00 0
R 020B 1 02 02 0
R 020C 0 01 00 0
R 020D 1 03 00 0
R 020E 0 04 00 0
R 020F 0 01 00 0
R 0214 1 05 02 0
R 0215 0 04 00 0
R 0216 0 08 00 0
R 0217 0 01 00 0
R 01F6 1 06 00 0
R 01F7 0 04 00 0
R 01F8 0 08 00 0
R 01F9 0 10 00 0
R FFFE 0 20 00 0
R FFFF 0 40 00 0
R 01FA 0 01 00 0
R 0300 1 02 00 0
R 0301 0 04 00 1
R 0302 0 08 00 1
R 0303 0 01 00 1
R 0304 1 02 00 1
R 0305 0 04 00 0
R 0306 0 08 00 0
R 0307 0 10 00 0
R FFFE 0 20 00 0
R FFFF 0 40 00 0
R 0308 0 01 00 0
R 0300 1 02 00 0
